// File: sim.f
verilog/uart_pkg.sv
verilog/uart_baud.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
bench/uart_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the UART testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/1ps --top-module uart_tb \
        -f sim.f -o uart_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/uart_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: bench/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    logic                 clk;
    logic                 rst_n;
    logic                 a_valid;
    uart_pkg::tl_a_t      a;
    logic                 d_ready;
    wire                  a_ready;
    wire                  d_valid;
    wire uart_pkg::tl_d_t d;
    wire                  serial;  // Loopback from txd to rxd.

    integer seed = 32'hf99e_4e3c;
    int     checks = 0;
    int     errors = 0;
    int     err_mark = 0;
    int     last_latency;
    logic [3:0] src = 4'd0;

    // Register model state.
    logic [7:0] m_ier = 8'h00;
    logic [7:0] m_lcr = 8'h00;
    logic [7:0] m_mcr = 8'h00;
    logic [7:0] m_scr = 8'h00;
    logic [7:0] m_dll = 8'h01;
    logic [7:0] m_dlm = 8'h00;
    logic [7:0] m_rbr = 8'h00;
    logic       m_dr  = 1'b0;
    logic       m_oe  = 1'b0;

    // Expected responses in request order.
    uart_pkg::tl_d_t exp_q[$];
    logic [7:0]      mask_q[$];
    uart_pkg::tl_d_t exp_d;
    logic [7:0]      exp_m;

    uart_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .a_valid (a_valid),
        .a_ready (a_ready),
        .a       (a),
        .d_valid (d_valid),
        .d_ready (d_ready),
        .d       (d),
        .rxd     (serial),
        .txd     (serial)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ************************************************************************
    // Reference model and checker
    // ************************************************************************

    function automatic uart_pkg::tl_d_t ref_resp(input uart_pkg::tl_a_t req);
        uart_pkg::tl_d_t r;
        logic            dlab;
        dlab     = m_lcr[uart_pkg::lcr_dlab];
        r.opcode = (req.opcode == uart_pkg::tl_get) ? uart_pkg::tl_access_ack_data
                                                    : uart_pkg::tl_access_ack;
        r.size   = req.size;
        r.source = req.source;
        r.denied = (req.address >= 8'd8);
        r.data   = 8'h00;
        if (req.opcode == uart_pkg::tl_get && !r.denied) begin
            case (req.address[2:0])
                uart_pkg::reg_rbr: r.data = dlab ? m_dll : m_rbr;
                uart_pkg::reg_ier: r.data = dlab ? m_dlm : m_ier;
                uart_pkg::reg_iir: r.data = 8'h01;  // Nothing pending.
                uart_pkg::reg_lcr: r.data = m_lcr;
                uart_pkg::reg_mcr: r.data = m_mcr;
                uart_pkg::reg_lsr: r.data = uart_pkg::lsr_thre | uart_pkg::lsr_temt
                                          | (m_oe ? uart_pkg::lsr_oe : 8'h00)
                                          | (m_dr ? uart_pkg::lsr_dr : 8'h00);
                uart_pkg::reg_msr: r.data = 8'h00;
                default:           r.data = m_scr;
            endcase
        end
        return r;
    endfunction

    // Side effects of an accepted request on the model.
    task automatic model_update(input uart_pkg::tl_a_t req);
        logic dlab;
        dlab = m_lcr[uart_pkg::lcr_dlab];
        if (req.address < 8'd8) begin
            if (req.opcode == uart_pkg::tl_put_full) begin
                case (req.address[2:0])
                    uart_pkg::reg_rbr: begin
                        if (dlab) begin
                            m_dll = req.data;
                        end
                    end
                    uart_pkg::reg_ier: begin
                        if (dlab) begin
                            m_dlm = req.data;
                        end else begin
                            m_ier = req.data;
                        end
                    end
                    uart_pkg::reg_lcr: m_lcr = req.data;
                    uart_pkg::reg_mcr: m_mcr = req.data;
                    uart_pkg::reg_scr: m_scr = req.data;
                    default: ;
                endcase
            end else if (req.address[2:0] == uart_pkg::reg_rbr && !dlab) begin
                m_dr = 1'b0;
            end else if (req.address[2:0] == uart_pkg::reg_lsr) begin
                m_oe = 1'b0;
            end
        end
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Every completed response is compared with the model.
    always @(posedge clk) begin
        if (rst_n && d_valid && d_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("A response arrived at %0t ns with no request outstanding", $time);
            end else begin
                exp_d = exp_q.pop_front();
                exp_m = mask_q.pop_front();
                check(32'(d.opcode), 32'(exp_d.opcode), "response opcode");
                check(32'(d.size), 32'(exp_d.size), "response size");
                check(32'(d.source), 32'(exp_d.source), "response source");
                check(32'(d.denied), 32'(exp_d.denied), "response denied");
                check(32'(d.data & exp_m), 32'(exp_d.data & exp_m), "response data");
            end
        end
    end

    // ************************************************************************
    // Bus tasks
    // ************************************************************************

    function automatic uart_pkg::tl_a_t make_req(input logic [2:0] opcode,
                                                  input logic [7:0] addr,
                                                  input logic [7:0] data);
        uart_pkg::tl_a_t r;
        r.opcode  = opcode;
        r.size    = 2'($random(seed));
        r.source  = src;
        r.address = addr;
        r.data    = data;
        return r;
    endfunction

    // One request and its response; stall holds d_ready low for that many cycles.
    task automatic transfer(input uart_pkg::tl_a_t req, input logic [7:0] mask,
                            input int stall, output logic [7:0] rdata);
        uart_pkg::tl_d_t held;
        int              lat;
        exp_q.push_back(ref_resp(req));
        mask_q.push_back(mask);
        src = src + 4'd1;
        @(negedge clk);
        a_valid = 1'b1;
        a       = req;
        d_ready = (stall == 0);
        @(posedge clk);
        while (!a_ready) begin
            @(posedge clk);
        end
        model_update(req);
        @(negedge clk);
        a_valid = 1'b0;
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            if (i == 0) begin
                held = d;
            end else begin
                check(32'(d), 32'(held), "d held under back-pressure");
            end
            check(32'(d_valid), 32'd1, "d_valid under back-pressure");
            check(32'(a_ready), 32'd0, "a_ready under back-pressure");
        end
        if (stall > 0) begin
            @(negedge clk);
            d_ready = 1'b1;
        end
        @(posedge clk);
        lat = 1;
        while (!(d_valid && d_ready)) begin
            @(posedge clk);
            lat = lat + 1;
        end
        rdata        = d.data;
        last_latency = lat;
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [7:0] mask,
                            output logic [7:0] rdata);
        transfer(make_req(uart_pkg::tl_get, addr, 8'h00), mask, 0, rdata);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        transfer(make_req(uart_pkg::tl_put_full, addr, data), 8'h00, 0, unused);
    endtask

    task automatic write_and_read(input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] v;
        write_reg(addr, data);
        read_reg(addr, 8'hff, v);
    endtask

    // Poll LSR until one of the given bits shows.
    task automatic poll_lsr(input logic [7:0] bits, output logic [7:0] value);
        value = 8'h00;
        while ((value & bits) == 8'h00) begin
            read_reg(8'(uart_pkg::reg_lsr), 8'h00, value);
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("Test %0d (%s): %s", num, name, (errors == err_mark) ? "ok" : "failed");
        err_mark = errors;
    endtask

    // ************************************************************************
    // Tests
    // ************************************************************************

    initial begin
        logic [7:0] v;
        logic [7:0] b0;
        logic [7:0] b1;
        rst_n   = 1'b0;
        a_valid = 1'b0;
        a       = '0;
        d_ready = 1'b1;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < 8; i++) begin
            read_reg(8'(i), 8'hff, v);
            if (i == 0) begin
                check(32'(last_latency), 32'd1, "first response latency");
            end
        end
        report_test(1, "reset values");

        write_and_read(8'(uart_pkg::reg_scr), 8'($random(seed)));
        write_and_read(8'(uart_pkg::reg_ier), 8'($random(seed)));
        write_and_read(8'(uart_pkg::reg_mcr), 8'($random(seed)));
        write_and_read(8'(uart_pkg::reg_lcr), 8'($random(seed)) & 8'h7f);  // DLAB clear.
        read_reg(8'(uart_pkg::reg_msr), 8'hff, v);
        report_test(2, "register storage");

        write_and_read(8'(uart_pkg::reg_lcr), 8'h83);
        write_and_read(8'(uart_pkg::reg_rbr), 8'($random(seed)));  // DLL.
        write_and_read(8'(uart_pkg::reg_ier), 8'($random(seed)));  // DLM.
        write_and_read(8'(uart_pkg::reg_rbr), 8'h02);              // Divisor 2 from here on.
        write_and_read(8'(uart_pkg::reg_ier), 8'h00);
        write_and_read(8'(uart_pkg::reg_lcr), 8'h03);
        read_reg(8'(uart_pkg::reg_ier), 8'hff, v);
        report_test(3, "divisor aliasing");

        for (int n = 0; n < 8; n++) begin
            b0 = 8'($random(seed));
            write_reg(8'(uart_pkg::reg_rbr), b0);
            poll_lsr(uart_pkg::lsr_dr, v);
            m_dr  = 1'b1;
            m_rbr = b0;
            read_reg(8'(uart_pkg::reg_rbr), 8'hff, v);
            poll_lsr(uart_pkg::lsr_temt, v);
            read_reg(8'(uart_pkg::reg_lsr), 8'hff, v);  // DR clear, THRE and TEMT set.
        end
        report_test(4, "loopback");

        b0 = 8'($random(seed));
        b1 = 8'($random(seed));
        write_reg(8'(uart_pkg::reg_rbr), b0);
        write_reg(8'(uart_pkg::reg_rbr), b1);
        poll_lsr(uart_pkg::lsr_oe, v);
        check(32'(v & uart_pkg::lsr_dr), 32'(uart_pkg::lsr_dr), "DR alongside overrun");
        m_dr  = 1'b1;
        m_rbr = b0;  // Second byte is lost.
        poll_lsr(uart_pkg::lsr_temt, v);
        read_reg(8'(uart_pkg::reg_lsr), 8'hff, v);  // OE cleared by the earlier read.
        read_reg(8'(uart_pkg::reg_rbr), 8'hff, v);
        read_reg(8'(uart_pkg::reg_lsr), 8'hff, v);
        write_reg(8'h0f, 8'($random(seed)));
        read_reg(8'(uart_pkg::reg_scr), 8'hff, v);
        read_reg(8'h09, 8'hff, v);
        transfer(make_req(uart_pkg::tl_get, 8'(uart_pkg::reg_scr), 8'h00), 8'hff, 4, v);
        report_test(5, "overrun and bus handling");

        $display("Checks run: %0d, failures: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Sized for the loopback frames at divisor 2 plus margin.
    initial begin
        int limit;
        limit = 8 * 10 * uart_pkg::oversample * 2 + 2000;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   a_valid,
    output wire                   a_ready,
    input  wire uart_pkg::tl_a_t  a,
    output wire                   d_valid,
    input  wire                   d_ready,
    output wire uart_pkg::tl_d_t  d,
    input  wire                   rxd,
    output wire                   txd
);

    logic [15:0] divisor;
    logic        tick;
    logic        tx_load;
    logic [7:0]  tx_byte;
    logic        tx_idle;
    logic        rx_valid;
    logic [7:0]  rx_byte;

    // Bus side.
    uart_regs u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .a_valid  (a_valid),
        .a_ready  (a_ready),
        .a        (a),
        .d_valid  (d_valid),
        .d_ready  (d_ready),
        .d        (d),
        .divisor  (divisor),
        .tx_load  (tx_load),
        .tx_byte  (tx_byte),
        .tx_idle  (tx_idle),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

    uart_baud u_baud (
        .clk     (clk),
        .rst_n   (rst_n),
        .divisor (divisor),
        .tick    (tick)
    );

    // Serial side.
    uart_tx u_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .tx_load (tx_load),
        .tx_byte (tx_byte),
        .tx_idle (tx_idle),
        .txd     (txd)
    );

    uart_rx u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte)
    );

endmodule

`default_nettype wire

// File: verilog/uart_regs.sv
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   a_valid,
    output logic                  a_ready,
    input  wire uart_pkg::tl_a_t  a,
    output logic                  d_valid,
    input  wire                   d_ready,
    output uart_pkg::tl_d_t       d,
    output logic [15:0]           divisor,
    output logic                  tx_load,
    output logic [7:0]            tx_byte,
    input  wire                   tx_idle,
    input  wire                   rx_valid,
    input  wire  [7:0]            rx_byte
);

    logic       accept;
    logic       is_get;
    logic       is_put;
    logic       addr_ok;
    logic       dlab;
    logic [2:0] off;
    logic       wr_en;
    logic       rd_en;
    logic       thr_wr;
    logic       rbr_read;
    logic       lsr_read;
    logic [7:0] ier;
    logic [7:0] lcr;
    logic [7:0] mcr;
    logic [7:0] scr;
    logic [7:0] dll;
    logic [7:0] dlm;
    logic [7:0] thr;
    logic [7:0] rbr;
    logic       thr_full;
    logic       rx_full;
    logic       overrun;
    logic [7:0] lsr;
    logic [7:0] rdata;

    // One request in flight; stall while a response waits.
    assign a_ready = !(d_valid && !d_ready);
    assign accept  = a_valid && a_ready;

    assign is_get  = (a.opcode == uart_pkg::tl_get);
    assign is_put  = (a.opcode == uart_pkg::tl_put_full);
    assign addr_ok = (a.address[7:3] == 5'd0);
    assign off     = a.address[2:0];
    assign dlab    = lcr[uart_pkg::lcr_dlab];

    assign wr_en    = accept && is_put && addr_ok;
    assign rd_en    = accept && is_get && addr_ok;
    assign thr_wr   = wr_en && (off == uart_pkg::reg_rbr) && !dlab;
    assign rbr_read = rd_en && (off == uart_pkg::reg_rbr) && !dlab;
    assign lsr_read = rd_en && (off == uart_pkg::reg_lsr);

    assign divisor = {dlm, dll};
    assign tx_load = thr_full && tx_idle;  // Hand the byte over once the shifter is free.
    assign tx_byte = thr;

    assign lsr = (rx_full ? uart_pkg::lsr_dr : 8'h00)
               | (overrun ? uart_pkg::lsr_oe : 8'h00)
               | (!thr_full ? uart_pkg::lsr_thre : 8'h00)
               | ((!thr_full && tx_idle) ? uart_pkg::lsr_temt : 8'h00);

    // Read mux.
    always_comb begin
        case (off)
            uart_pkg::reg_rbr: rdata = dlab ? dll : rbr;
            uart_pkg::reg_ier: rdata = dlab ? dlm : ier;
            uart_pkg::reg_iir: rdata = 8'h01;  // No interrupt pending.
            uart_pkg::reg_lcr: rdata = lcr;
            uart_pkg::reg_mcr: rdata = mcr;
            uart_pkg::reg_lsr: rdata = lsr;
            uart_pkg::reg_msr: rdata = 8'h00;
            default:           rdata = scr;
        endcase
    end

    // ************************************************************************
    // Register file and line flags
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ier      <= 8'h00;
            lcr      <= 8'h00;
            mcr      <= 8'h00;
            scr      <= 8'h00;
            dll      <= 8'h01;
            dlm      <= 8'h00;
            rbr      <= 8'h00;
            thr_full <= 1'b0;
            rx_full  <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            if (wr_en) begin
                case (off)
                    uart_pkg::reg_rbr: begin
                        if (dlab) begin
                            dll <= a.data;
                        end
                    end
                    uart_pkg::reg_ier: begin
                        if (dlab) begin
                            dlm <= a.data;
                        end else begin
                            ier <= a.data;
                        end
                    end
                    uart_pkg::reg_lcr: lcr <= a.data;
                    uart_pkg::reg_mcr: mcr <= a.data;
                    uart_pkg::reg_scr: scr <= a.data;
                    default: ;  // FCR, LSR and MSR writes are dropped.
                endcase
            end

            if (tx_load) begin
                thr_full <= 1'b0;
            end
            if (thr_wr) begin
                thr_full <= 1'b1;  // A new write wins over the hand-off.
            end

            if (rbr_read) begin
                rx_full <= 1'b0;
            end
            if (lsr_read) begin
                overrun <= 1'b0;
            end
            if (rx_valid) begin
                if (rx_full && !rbr_read) begin
                    overrun <= 1'b1;  // Keep the old byte.
                end else begin
                    rbr     <= rx_byte;
                    rx_full <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (thr_wr) begin
            thr <= a.data;
        end
    end

    // ************************************************************************
    // Response channel
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (accept) begin
            d_valid <= 1'b1;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            d.opcode <= is_get ? uart_pkg::tl_access_ack_data : uart_pkg::tl_access_ack;
            d.size   <= a.size;
            d.source <= a.source;
            d.denied <= !addr_ok;
            d.data   <= (is_get && addr_ok) ? rdata : 8'h00;
        end
    end

    // Response must hold under back-pressure.
    a_d_stable: assert property (@(posedge clk) disable iff (!rst_n)
        d_valid && !d_ready |=> d_valid && $stable(d));

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        tick,
    input  wire        rxd,
    output logic       rx_valid,
    output logic [7:0] rx_byte
);

    typedef enum logic [1:0] {
        s_idle,
        s_start,
        s_data,
        s_stop
    } state_t;

    state_t     state;
    logic       rxd_s1;
    logic       rxd_s2;
    logic       rxd_q;
    logic [3:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic       mid_start;
    logic       mid_bit;

    assign mid_start = (tick_cnt == 4'(uart_pkg::oversample / 2 - 1));
    assign mid_bit   = (tick_cnt == 4'(uart_pkg::oversample - 1));

    // Two-stage synchronizer plus edge history.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
            rxd_q  <= 1'b1;
        end else begin
            rxd_s1 <= rxd;
            rxd_s2 <= rxd_s1;
            rxd_q  <= rxd_s2;
        end
    end

    // ************************************************************************
    // Frame FSM
    // ************************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= s_idle;
            tick_cnt <= 4'd0;
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                s_idle: begin
                    if (rxd_q && !rxd_s2) begin
                        state    <= s_start;  // Falling edge.
                        tick_cnt <= 4'd0;
                    end
                end
                s_start: begin
                    if (tick && mid_start) begin
                        tick_cnt <= 4'd0;
                        bit_cnt  <= 3'd0;
                        state    <= rxd_s2 ? s_idle : s_data;  // Glitch rejected.
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                    end
                end
                s_data: begin
                    if (tick && mid_bit) begin
                        tick_cnt <= 4'd0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= s_stop;
                        end
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                    end
                end
                default: begin
                    if (tick && mid_bit) begin
                        tick_cnt <= 4'd0;
                        rx_valid <= rxd_s2;  // Framing error drops the byte.
                        state    <= s_idle;
                    end else if (tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_data && tick && mid_bit) begin
            rx_byte <= {rxd_s2, rx_byte[7:1]};  // LSB arrives first.
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        tick,
    input  wire        tx_load,
    input  wire  [7:0] tx_byte,
    output logic       tx_idle,
    output logic       txd
);

    logic       busy;
    logic       started;
    logic [3:0] tick_cnt;
    logic [3:0] bit_cnt;
    logic [9:0] shreg;
    logic       bit_end;
    logic       shift_en;

    assign tx_idle  = !busy;
    assign bit_end  = (tick_cnt == 4'(uart_pkg::oversample - 1));
    // First tick drives the start bit, later ones advance at each bit boundary.
    assign shift_en = busy && tick && (!started || (bit_end && bit_cnt != 4'd9));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            started  <= 1'b0;
            tick_cnt <= 4'd0;
            bit_cnt  <= 4'd0;
            txd      <= 1'b1;  // Line idles high.
        end else if (tx_load) begin
            busy     <= 1'b1;
            started  <= 1'b0;
            tick_cnt <= 4'd0;
            bit_cnt  <= 4'd0;
        end else if (busy && tick) begin
            if (!started) begin
                started <= 1'b1;
                txd     <= shreg[0];
            end else if (bit_end) begin
                tick_cnt <= 4'd0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;  // Stop bit done.
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    txd     <= shreg[0];
                end
            end else begin
                tick_cnt <= tick_cnt + 4'd1;
            end
        end
    end

    // Frame is stop, data LSB first, start.
    always_ff @(posedge clk) begin
        if (tx_load) begin
            shreg <= {1'b1, tx_byte, 1'b0};
        end else if (shift_en) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

    a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_load |-> tx_idle);

endmodule

`default_nettype wire

// File: verilog/uart_baud.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [15:0] divisor,
    output logic        tick
);

    logic [15:0] div_in;
    logic [15:0] div_q;
    logic [15:0] cnt;

    assign div_in = (divisor == 16'd0) ? 16'd1 : divisor;  // Zero acts as one.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_q <= 16'd1;
            cnt   <= 16'd0;
            tick  <= 1'b0;
        end else if (div_in != div_q) begin
            div_q <= div_in;       // Restart on a new divisor.
            cnt   <= div_in - 16'd1;
            tick  <= 1'b0;
        end else if (cnt == 16'd0) begin
            cnt   <= div_q - 16'd1;
            tick  <= 1'b1;
        end else begin
            cnt   <= cnt - 16'd1;
            tick  <= 1'b0;
        end
    end

    a_tick_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        tick |=> !tick || (div_q == 16'd1));

endmodule

`default_nettype wire

// File: verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ************************************************************************
    // 16550 register map
    // ************************************************************************

    localparam logic [2:0] reg_rbr = 3'd0;  // Also THR on write, DLL with DLAB.
    localparam logic [2:0] reg_ier = 3'd1;  // Also DLM with DLAB.
    localparam logic [2:0] reg_iir = 3'd2;  // Also FCR on write.
    localparam logic [2:0] reg_lcr = 3'd3;
    localparam logic [2:0] reg_mcr = 3'd4;
    localparam logic [2:0] reg_lsr = 3'd5;
    localparam logic [2:0] reg_msr = 3'd6;
    localparam logic [2:0] reg_scr = 3'd7;

    // Line status bits.
    localparam logic [7:0] lsr_dr   = 8'h01;  // Data ready.
    localparam logic [7:0] lsr_oe   = 8'h02;  // Overrun error.
    localparam logic [7:0] lsr_thre = 8'h20;  // Holding register empty.
    localparam logic [7:0] lsr_temt = 8'h40;  // Transmitter empty.

    localparam int lcr_dlab = 7;  // Divisor latch access bit.

    // Ticks per serial bit.
    localparam int oversample = 16;

    // ************************************************************************
    // TileLink-UL channels
    // ************************************************************************

    localparam logic [2:0] tl_get             = 3'd4;
    localparam logic [2:0] tl_put_full        = 3'd0;
    localparam logic [2:0] tl_access_ack      = 3'd0;
    localparam logic [2:0] tl_access_ack_data = 3'd1;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] size;
        logic [3:0] source;
        logic [7:0] address;
        logic [7:0] data;
    } tl_a_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] size;
        logic [3:0] source;
        logic       denied;
        logic [7:0] data;
    } tl_d_t;

endpackage

`default_nettype wire
